// File: hdl/addend_aligner.sv
// aligns the addend against the a*b product in a fixed window; no infinity or NaN handling
`timescale 1ns/1ps

module addend_aligner (
    input  logic                                 sign_a,
    input  logic                                 sign_b,
    input  logic                                 sign_c,
    input  logic signed [fma_row_pkg::EXP_W-1:0] exp_a,
    input  logic signed [fma_row_pkg::EXP_W-1:0] exp_b,
    input  logic signed [fma_row_pkg::EXP_W-1:0] exp_c,
    input  logic [fp16_pkg::FP16_MANT_W-1:0]     mant_c,
    output logic                                 sign_ab,
    output logic                                 eff_sub,
    output logic signed [fma_row_pkg::EXP_W-1:0] exp_ab,
    output logic [fma_row_pkg::ALIGN_W-1:0]      aligned_c,
    output logic                                 c_sticky,
    output logic                                 c_dominant
);
    import fp16_pkg::*;
    import fma_row_pkg::*;

    logic signed [EXP_W-1:0]     exp_prod;  // exponent of a*b
    logic signed [EXP_W-1:0]     gap;
    logic signed [EXP_W-1:0]     pos;   // window bit of the addend lsb
    logic [EXP_W-1:0]            rsh;
    logic [2*FP16_MANT_W-1:0]    tail;

    assign sign_ab  = sign_a ^ sign_b;
    assign eff_sub  = sign_ab ^ sign_c;
    assign exp_prod = exp_a + exp_b;

    assign gap = exp_c - exp_prod;
    assign pos = gap + EXP_W'(PROD_LSB + FP16_FRAC_W);

    assign c_dominant = gap > $signed(EXP_W'(DOMINANT_SHIFT));

    // a pinned addend sits where a gap of DOMINANT_SHIFT would put it
    assign exp_ab = c_dominant ? exp_c - EXP_W'(DOMINANT_SHIFT) : exp_prod;

    always_comb begin
        aligned_c = '0;
        c_sticky  = 1'b0;
        rsh       = '0;
        tail      = '0;
        if (c_dominant) begin
            aligned_c = ALIGN_W'(mant_c) << (ALIGN_W - FP16_MANT_W);  // pinned to the top
        end else if (!pos[EXP_W-1]) begin
            aligned_c = ALIGN_W'(mant_c) << pos;
        end else begin
            // addend falls partly or wholly below the window
            rsh = -pos;
            if (rsh > EXP_W'(FP16_MANT_W)) begin
                rsh = EXP_W'(FP16_MANT_W);
            end
            tail      = {mant_c, {FP16_MANT_W{1'b0}}} >> rsh;
            aligned_c = ALIGN_W'(tail[2*FP16_MANT_W-1:FP16_MANT_W]);
            c_sticky  = |tail[FP16_MANT_W-1:0];  // bits lost off the bottom
        end
    end

endmodule

// File: hdl/booth_multiplier.sv
// unsigned 11x11 mantissa product, exact; combinational with no pipelining inside
`timescale 1ns/1ps

module booth_multiplier (
    input  logic [fp16_pkg::FP16_MANT_W-1:0] mant_a,
    input  logic [fp16_pkg::FP16_MANT_W-1:0] mant_b,
    output logic [fma_row_pkg::PROD_W-1:0]   product
);
    import fp16_pkg::*;
    import fma_row_pkg::*;

    logic [PROD_W-1:0]        pos1, pos2, neg1, neg2;
    logic [FP16_MANT_W+1:0]   b_ext;
    logic [PROD_W-1:0]        pp [BOOTH_DIGITS];
    logic [2*PROD_W-1:0]      l1_lo, l1_hi, l2, l3;

    // one row of full adders, returns {carry, sum}
    function automatic logic [2*PROD_W-1:0] csa(input logic [PROD_W-1:0] x,
                                                input logic [PROD_W-1:0] y,
                                                input logic [PROD_W-1:0] z);
        logic [PROD_W-1:0] s;
        logic [PROD_W-1:0] cy;
        s  = x ^ y ^ z;
        cy = ((x & y) | (y & z) | (x & z)) << 1;
        return {cy, s};
    endfunction

    // multiples of a, two's complement mod 2^PROD_W
    assign pos1 = PROD_W'(mant_a);
    assign pos2 = PROD_W'({mant_a, 1'b0});
    assign neg1 = ~pos1 + 1'b1;
    assign neg2 = ~pos2 + 1'b1;

    assign b_ext = {1'b0, mant_b, 1'b0};  // zero on top keeps b positive

    always_comb begin
        for (int i = 0; i < BOOTH_DIGITS; i++) begin
            case (b_ext[2*i +: 3])
                3'b001, 3'b010: pp[i] = pos1 << (2 * i);
                3'b011:         pp[i] = pos2 << (2 * i);
                3'b100:         pp[i] = neg2 << (2 * i);
                3'b101, 3'b110: pp[i] = neg1 << (2 * i);
                default:        pp[i] = '0;  // 000 and 111
            endcase
        end
    end

    // 6 rows -> 4 -> 3 -> 2
    assign l1_lo = csa(pp[0], pp[1], pp[2]);
    assign l1_hi = csa(pp[3], pp[4], pp[5]);
    assign l2    = csa(l1_lo[PROD_W-1:0], l1_lo[2*PROD_W-1:PROD_W], l1_hi[PROD_W-1:0]);
    assign l3    = csa(l2[PROD_W-1:0], l2[2*PROD_W-1:PROD_W], l1_hi[2*PROD_W-1:PROD_W]);

    // final carry-propagate add, wraps to the positive product
    assign product = l3[PROD_W-1:0] + l3[2*PROD_W-1:PROD_W];

endmodule

// File: hdl/fma_row.sv
// row of FP16 FMA lanes, a*b[i]+c[i], two pipeline stages; inf, NaN and overflow are not handled
`timescale 1ns/1ps

module fma_row (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  fp16_pkg::fp16_word_u a,
    input  fp16_pkg::fp16_word_u b [fma_row_pkg::FMA_LANES],
    input  fp16_pkg::fp16_word_u c [fma_row_pkg::FMA_LANES],
    output logic                 out_valid,
    input  logic                 out_ready,
    output fp16_pkg::fp16_word_u result [fma_row_pkg::FMA_LANES]
);
    import fp16_pkg::*;
    import fma_row_pkg::*;

    logic                     s1_en;       // input transfer
    logic                     s2_adv;      // output register may load
    logic                     s1_valid;

    // shared a operand, decoded once
    logic                     sign_a;
    logic signed [EXP_W-1:0]  exp_a;
    logic [FP16_MANT_W-1:0]   mant_a;

    // stage-1 inputs from the lane datapaths
    logic [PROD_W-1:0]        p1_product  [FMA_LANES];
    logic                     p1_sign_ab  [FMA_LANES];
    logic                     p1_eff_sub  [FMA_LANES];
    logic signed [EXP_W-1:0]  p1_exp_ab   [FMA_LANES];
    logic [ALIGN_W-1:0]       p1_aligned  [FMA_LANES];
    logic                     p1_sticky   [FMA_LANES];
    logic                     p1_dominant [FMA_LANES];

    // stage-1 register
    logic [PROD_W-1:0]        s1_product  [FMA_LANES];
    logic                     s1_sign_ab  [FMA_LANES];
    logic                     s1_eff_sub  [FMA_LANES];
    logic signed [EXP_W-1:0]  s1_exp_ab   [FMA_LANES];
    logic [ALIGN_W-1:0]       s1_aligned  [FMA_LANES];
    logic                     s1_sticky   [FMA_LANES];
    logic                     s1_dominant [FMA_LANES];

    fp16_word_u               rounded     [FMA_LANES];

    function automatic logic [FP16_MANT_W-1:0] mant_of(input fp16_word_u w);
        return {|w.f.exp, w.f.frac};
    endfunction

    // subnormals share the smallest normal exponent
    function automatic logic signed [EXP_W-1:0] exp_of(input fp16_word_u w, input logic hidden);
        return hidden ? EXP_W'(w.f.exp) - EXP_W'(FP16_BIAS) : EXP_W'(FP16_EMIN);
    endfunction

    assign sign_a = a.f.sign;
    assign mant_a = mant_of(a);
    assign exp_a  = exp_of(a, mant_a[FP16_MANT_W-1]);

    // handshake
    assign s2_adv   = ~out_valid | out_ready;
    assign in_ready = ~s1_valid | s2_adv;
    assign s1_en    = in_valid & in_ready;

    generate
        for (genvar i = 0; i < FMA_LANES; i++) begin : g_lane
            logic [FP16_MANT_W-1:0] mant_b, mant_c;

            assign mant_b = mant_of(b[i]);
            assign mant_c = mant_of(c[i]);

            booth_multiplier u_mul (
                .mant_a  (mant_a),
                .mant_b  (mant_b),
                .product (p1_product[i])
            );

            addend_aligner u_align (
                .sign_a     (sign_a),
                .sign_b     (b[i].f.sign),
                .sign_c     (c[i].f.sign),
                .exp_a      (exp_a),
                .exp_b      (exp_of(b[i], mant_b[FP16_MANT_W-1])),
                .exp_c      (exp_of(c[i], mant_c[FP16_MANT_W-1])),
                .mant_c     (mant_c),
                .sign_ab    (p1_sign_ab[i]),
                .eff_sub    (p1_eff_sub[i]),
                .exp_ab     (p1_exp_ab[i]),
                .aligned_c  (p1_aligned[i]),
                .c_sticky   (p1_sticky[i]),
                .c_dominant (p1_dominant[i])
            );

            normalize_round u_round (
                .product    (s1_product[i]),
                .aligned_c  (s1_aligned[i]),
                .c_sticky   (s1_sticky[i]),
                .c_dominant (s1_dominant[i]),
                .eff_sub    (s1_eff_sub[i]),
                .sign_ab    (s1_sign_ab[i]),
                .exp_ab     (s1_exp_ab[i]),
                .result     (rounded[i])
            );
        end
    endgenerate

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (in_ready) s1_valid <= in_valid;   // empty or draining into stage 2
            if (s2_adv) out_valid <= s1_valid;
        end
    end

    // payload, loads only on a transfer
    always_ff @(posedge clk) begin
        for (int i = 0; i < FMA_LANES; i++) begin
            if (s1_en) begin
                s1_product[i]  <= p1_product[i];
                s1_sign_ab[i]  <= p1_sign_ab[i];
                s1_eff_sub[i]  <= p1_eff_sub[i];
                s1_exp_ab[i]   <= p1_exp_ab[i];
                s1_aligned[i]  <= p1_aligned[i];
                s1_sticky[i]   <= p1_sticky[i];
                s1_dominant[i] <= p1_dominant[i];
            end
            if (s2_adv && s1_valid) result[i] <= rounded[i];  // holds while stalled
        end
    end

endmodule

// File: hdl/fma_row_pkg.sv
// widths of the FMA row datapath; the window layout assumes FP16 operands and no overflow
package fma_row_pkg;

    localparam int FMA_LANES = 4;        // lanes sharing one a operand

    // signed unbiased exponent, covers product exponent sums and shifts
    localparam int EXP_W = 7;

    localparam int PROD_W       = 2 * fp16_pkg::FP16_MANT_W;         // 22
    localparam int BOOTH_DIGITS = (fp16_pkg::FP16_MANT_W + 2) / 2;   // radix-4 digits, 6

    // sum window, product sits at a fixed position inside it
    localparam int ALIGN_W        = 40;
    localparam int DOMINANT_SHIFT = 13;  // larger gap: product only feeds sticky

    // lsb of the product in the window; c at gap DOMINANT_SHIFT reaches the top bit
    localparam int PROD_LSB = ALIGN_W - fp16_pkg::FP16_MANT_W - DOMINANT_SHIFT
                              - fp16_pkg::FP16_FRAC_W;

    // adder width: one carry bit on top, one sticky bit below the window
    localparam int SUM_W       = ALIGN_W + 2;
    localparam int SUM_SHIFT_W = $clog2(SUM_W);

endpackage

// File: hdl/fp16_pkg.sv
// IEEE half precision format only; infinity and NaN encodings are never produced or decoded here
package fp16_pkg;

    localparam int FP16_W      = 16;
    localparam int FP16_EXP_W  = 5;
    localparam int FP16_FRAC_W = 10;
    localparam int FP16_MANT_W = FP16_FRAC_W + 1;  // with hidden bit
    localparam int FP16_BIAS   = 15;
    localparam int FP16_EMIN   = -14;              // subnormals and smallest normal

    // raw word and field view of the same 16 bits
    typedef union packed {
        logic [FP16_W-1:0] raw;
        struct packed {
            logic                   sign;
            logic [FP16_EXP_W-1:0]  exp;
            logic [FP16_FRAC_W-1:0] frac;
        } f;
    } fp16_word_u;

endpackage

// File: hdl/normalize_round.sv
// single RNE rounding of the fused sum; subnormal results flush to signed zero, no overflow check
`timescale 1ns/1ps

module normalize_round (
    input  logic [fma_row_pkg::PROD_W-1:0]       product,
    input  logic [fma_row_pkg::ALIGN_W-1:0]      aligned_c,
    input  logic                                 c_sticky,
    input  logic                                 c_dominant,
    input  logic                                 eff_sub,
    input  logic                                 sign_ab,
    input  logic signed [fma_row_pkg::EXP_W-1:0] exp_ab,
    output fp16_pkg::fp16_word_u                 result
);
    import fp16_pkg::*;
    import fma_row_pkg::*;

    logic [SUM_W-1:0]          p_ext;
    logic [SUM_W-1:0]          c_ext;
    logic [SUM_W:0]            sum;
    logic [SUM_W-1:0]          mag;
    logic [SUM_W-1:0]          norm;
    logic                      sum_neg, res_sign, is_zero;
    logic [SUM_SHIFT_W-1:0]    lead, lz, shamt;
    logic signed [EXP_W-1:0]   exp_room;
    logic signed [EXP_W-1:0]   exp_norm;
    logic signed [EXP_W-1:0]   exp_fin;
    logic [FP16_MANT_W-1:0]    mant, mant_rnd;
    logic [FP16_MANT_W:0]      mant_inc;
    logic                      guard, rnd, sticky, round_up;

    // product under the window, or just a sticky bit when c dominates
    assign p_ext = c_dominant ? SUM_W'(|product)
                              : SUM_W'({product, {(PROD_LSB + 1){1'b0}}});
    assign c_ext = {1'b0, aligned_c, c_sticky};

    assign sum = eff_sub ? {1'b0, p_ext} - {1'b0, c_ext}
                         : {1'b0, p_ext} + {1'b0, c_ext};
    assign sum_neg  = sum[SUM_W];  // only on subtraction
    assign mag      = sum_neg ? SUM_W'(-sum) : sum[SUM_W-1:0];
    assign res_sign = sign_ab ^ sum_neg;
    assign is_zero  = ~|mag;       // exact cancellation gives +0

    // leading one position
    always_comb begin
        lead = '0;
        for (int i = 0; i < SUM_W; i++) begin
            if (mag[i]) begin
                lead = SUM_SHIFT_W'(i);
            end
        end
    end
    assign lz = SUM_SHIFT_W'(SUM_W - 1) - lead;

    // left shift that still keeps the exponent at or above EMIN
    assign exp_room = exp_ab + EXP_W'(SUM_W - 2 - PROD_LSB - 2 * FP16_FRAC_W - FP16_EMIN);

    always_comb begin
        if ($signed(EXP_W'(lz)) > exp_room) begin
            shamt    = exp_room[SUM_SHIFT_W-1:0];  // stops at the subnormal exponent
            exp_norm = EXP_W'(FP16_EMIN);
        end else begin
            shamt    = lz;
            exp_norm = exp_room - EXP_W'(lz) + EXP_W'(FP16_EMIN);
        end
    end

    assign norm   = mag << shamt;
    assign mant   = norm[SUM_W-1 -: FP16_MANT_W];
    assign guard  = norm[SUM_W-1-FP16_MANT_W];
    assign rnd    = norm[SUM_W-2-FP16_MANT_W];
    assign sticky = |norm[SUM_W-3-FP16_MANT_W:0];

    // nearest even
    assign round_up = guard & (rnd | sticky | mant[0]);
    assign mant_inc = {1'b0, mant} + {{FP16_MANT_W{1'b0}}, round_up};

    // carry out means 1.0 at the next exponent
    assign mant_rnd = mant_inc[FP16_MANT_W] ? {1'b1, {FP16_FRAC_W{1'b0}}}
                                            : mant_inc[FP16_MANT_W-1:0];
    assign exp_fin  = exp_norm + EXP_W'(mant_inc[FP16_MANT_W]);

    always_comb begin
        result.raw = '0;
        if (!is_zero) begin
            result.f.sign = res_sign;
            if (mant_rnd[FP16_MANT_W-1]) begin
                result.f.exp  = FP16_EXP_W'(exp_fin + EXP_W'(FP16_BIAS));
                result.f.frac = mant_rnd[FP16_FRAC_W-1:0];
            end
            // no hidden bit: below the normal range, leave a signed zero
        end
    end

endmodule

// File: run.sh
#!/bin/bash
# builds the FMA row testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module fma_row_tb \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vfma_row_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^\*\* PASS \*\*$" "$LOG"; then
    exit 0
else
    exit 1
fi

// File: sources.f
hdl/fp16_pkg.sv
hdl/fma_row_pkg.sv
hdl/booth_multiplier.sv
hdl/addend_aligner.sv
hdl/normalize_round.sv
hdl/fma_row.sv
test/fma_row_props.sv
test/fma_row_tb.sv

// File: test/fma_row_props.sv
// handshake checks for fma_row, attached by bind; assumes an asynchronous active-low reset
`timescale 1ns/1ps

module fma_row_props (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 in_valid,
    input logic                 in_ready,
    input logic                 out_valid,
    input logic                 out_ready,
    input fp16_pkg::fp16_word_u result [fma_row_pkg::FMA_LANES]
);
    import fma_row_pkg::*;

    logic [1:0] in_flight;  // accepted and not yet delivered

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + 2'(in_valid && in_ready) - 2'(out_valid && out_ready);
        end
    end

    // a stalled result keeps out_valid up
    valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid dropped while stalled");

    generate
        for (genvar i = 0; i < FMA_LANES; i++) begin : g_stable
            result_held: assert property (@(posedge clk) disable iff (!rst_n)
                out_valid && !out_ready |=> $stable(result[i].raw))
                else $error("result lane %0d changed while stalled", i);
        end
    endgenerate

    valid_in_reset: assert property (@(posedge clk)
        !rst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // two stages hold at most two items
    no_overfill: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight != 2'd3)
        else $error("more than two items accepted and not delivered");

    // nothing in flight means both stages are empty
    ready_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight == 2'd0 |-> in_ready && !out_valid)
        else $error("in_ready low or out_valid high with both stages empty");

endmodule

bind fma_row fma_row_props i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result)
);

// File: test/fma_row_tb.sv
// random FMA row test against an exact integer model; operand exponents are kept below overflow
`timescale 1ns/1ps

module fma_row_tb;
    import fp16_pkg::*;
    import fma_row_pkg::*;

    localparam int SCALE = 96;  // model values are integers times 2^-96
    localparam int N1 = 200;
    localparam int N2 = 20;
    localparam int N3 = 30;
    localparam int N4 = 30;
    localparam int N5 = 100;
    localparam int N6 = 300;
    localparam int TOTAL_ITEMS = N1 + N2 + N3 + N4 + N5 + N6;

    logic       clk, rst_n, in_valid, in_ready, out_valid, out_ready;
    fp16_word_u a;
    fp16_word_u b [FMA_LANES];
    fp16_word_u c [FMA_LANES];
    fp16_word_u result [FMA_LANES];

    fp16_word_u nxt_a;
    fp16_word_u nxt_b [FMA_LANES];
    fp16_word_u nxt_c [FMA_LANES];
    fp16_word_u exp_q [$];   // expected results in lane order
    fp16_word_u ex;

    logic [31:0] rng, rdy_rng;
    logic        ready_random;
    int          errors, checks, accepted, received, tests;
    int          err_mark, chk_mark;

    fma_row i_fma_row (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic fp16_word_u rand_fp(input int lo, input int hi);
        fp16_word_u w;
        w.raw    = 16'(next_rand());
        w.f.exp  = FP16_EXP_W'(lo + int'(next_rand() % (hi - lo + 1)));
        return w;
    endfunction

    // signed value times 2^48
    function automatic logic signed [127:0] scaled(input fp16_word_u w);
        logic [10:0]          m;
        int                   e;
        logic signed [127:0]  v;
        m = {|w.f.exp, w.f.frac};
        e = (w.f.exp != 0) ? int'(w.f.exp) - FP16_BIAS : FP16_EMIN;
        v = 128'(m) <<< (e - FP16_FRAC_W + SCALE / 2);
        return w.f.sign ? -v : v;
    endfunction

    // rounds an exact value at 2^-SCALE to nearest even and flushes below 2^-14
    function automatic fp16_word_u round_fp16(input logic signed [127:0] x);
        logic [127:0] mag, mant, rem, half;
        logic         neg;
        int           lead, e, q;
        fp16_word_u   r;
        r.raw = '0;
        if (x == 0) return r;
        neg  = x < 0;
        mag  = neg ? -x : x;
        lead = 0;
        for (int i = 0; i < 128; i++) begin
            if (mag[i]) lead = i;
        end
        e = lead - SCALE;
        if (e < FP16_EMIN) e = FP16_EMIN;
        q    = e - FP16_FRAC_W + SCALE;
        mant = mag >> q;
        rem  = mag & ((128'd1 << q) - 1);
        half = 128'd1 << (q - 1);
        if (rem > half || (rem == half && mant[0])) mant = mant + 1;
        if (mant == 2048) begin
            mant = 1024;
            e    = e + 1;
        end
        r.f.sign = neg;
        if (mant >= 1024) begin
            r.f.exp  = FP16_EXP_W'(e + FP16_BIAS);
            r.f.frac = mant[9:0];
        end
        return r;
    endfunction

    task automatic send_item();
        @(negedge clk);
        in_valid = 1'b1;
        a        = nxt_a;
        for (int i = 0; i < FMA_LANES; i++) begin
            b[i] = nxt_b[i];
            c[i] = nxt_c[i];
            exp_q.push_back(round_fp16(scaled(nxt_a) * scaled(nxt_b[i])
                                       + (scaled(nxt_c[i]) <<< (SCALE / 2))));
        end
        do @(posedge clk); while (!in_ready);
        accepted++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic drain_and_report(input string name);
        idle(1);
        while (exp_q.size() != 0) @(posedge clk);
        @(negedge clk);
        tests++;
        $display("test %s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
        chk_mark = checks;
        err_mark = errors;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // output back-pressure from its own random stream
    initial begin
        out_ready = 1'b1;
        rdy_rng   = xorshift(32'd15);
        forever begin
            @(negedge clk);
            if (ready_random) begin
                rdy_rng   = xorshift(rdy_rng);
                out_ready = rdy_rng[3];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // scoreboard
    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            received++;
            for (int i = 0; i < FMA_LANES; i++) begin
                if (exp_q.size() == 0) begin
                    $display("result arrived with no accepted input pending");
                    errors++;
                end else begin
                    ex = exp_q.pop_front();
                    checks++;
                    if (result[i].raw !== ex.raw) begin
                        $display("[ERROR] result[%0d] got %h expected %h",
                                 i, result[i].raw, ex.raw);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        repeat (TOTAL_ITEMS * 20 + 50) @(posedge clk);
        $display("watchdog expired, results still pending");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rng = 32'd15;
        ready_random = 1'b0;
        errors = 0;
        checks = 0;
        accepted = 0;
        received = 0;
        tests = 0;
        err_mark = 0;
        chk_mark = 0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        a.raw = '0;
        for (int i = 0; i < FMA_LANES; i++) begin
            b[i].raw = '0;
            c[i].raw = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int n = 0; n < N1; n++) begin
            nxt_a = rand_fp(8, 21);
            for (int i = 0; i < FMA_LANES; i++) begin
                nxt_b[i] = rand_fp(8, 21);
                nxt_c[i] = rand_fp(8, 21);
            end
            send_item();
        end
        drain_and_report("random_normal");

        for (int n = 0; n < N2; n++) begin
            nxt_a = rand_fp(10, 20);
            nxt_a.f.frac[4:0] = '0;   // short mantissas keep a*b exact
            for (int i = 0; i < FMA_LANES; i++) begin
                nxt_b[i] = rand_fp(10, 20);
                nxt_b[i].f.frac[5:0] = '0;
                nxt_c[i] = round_fp16(scaled(nxt_a) * scaled(nxt_b[i]));
                nxt_c[i].f.sign = ~nxt_c[i].f.sign;
            end
            send_item();
        end
        drain_and_report("cancellation");

        for (int n = 0; n < N3; n++) begin
            nxt_a.raw = 16'h3c00;     // 1.0
            for (int i = 0; i < FMA_LANES; i++) begin
                nxt_c[i] = rand_fp(12, 25);
                nxt_b[i].raw = '0;
                nxt_b[i].f.sign = 1'(next_rand());
                nxt_b[i].f.exp = nxt_c[i].f.exp - 5'd11;  // half an ulp of c
            end
            send_item();
        end
        drain_and_report("halfway");

        for (int n = 0; n < N4; n++) begin
            nxt_a = rand_fp(5, 10);
            for (int i = 0; i < FMA_LANES; i++) begin
                nxt_b[i] = rand_fp(5, 10);
                nxt_c[i] = rand_fp(20, 25);
            end
            send_item();
        end
        drain_and_report("addend_dominant");

        for (int n = 0; n < N5; n++) begin
            nxt_a = rand_fp(1, 20);
            for (int i = 0; i < FMA_LANES; i++) begin
                nxt_b[i] = (next_rand() & 1) ? rand_fp(0, 0) : rand_fp(1, 6);
                nxt_c[i] = (next_rand() & 1) ? rand_fp(0, 0) : rand_fp(1, 4);
            end
            send_item();
        end
        drain_and_report("subnormal_underflow");

        ready_random = 1'b1;
        for (int n = 0; n < N6; n++) begin
            nxt_a = rand_fp(8, 21);
            for (int i = 0; i < FMA_LANES; i++) begin
                nxt_b[i] = rand_fp(8, 21);
                nxt_c[i] = rand_fp(8, 21);
            end
            send_item();
            if (next_rand() & 1) idle(1);
        end
        drain_and_report("backpressure");
        ready_random = 1'b0;

        if (received != accepted) begin
            $display("result count %0d does not match accepted inputs %0d", received, accepted);
            errors++;
        end
        $display("done: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
